//--- bench/procVectors.txt
# P lines give a hex instruction memory address and program word
# W lines give the expected register and value of each write, in commit order
P 00 C112
P 01 9134
P 02 C2F0
P 03 920F
P 04 417D
P 05 528A
P 06 D154
P 07 D159
P 08 D15E
P 09 D143
P 0A DA35
P 0B D959
P 0C D93C
P 0D D950
P 0E C340
P 0F 8322
P 10 8B82
P 11 C600
# beqz taken over 13, bnez falls through, j skips 17
P 12 6601
P 13 C7AA
P 14 6E01
P 15 47E1
P 16 2001
P 17 C055
P 18 401F
P 19 0000
W 1 0012
W 1 1234
W 2 FFF0
W 2 F00F
W 3 1231
W 4 F005
W 5 0243
W 6 2225
W 7 E23B
W 0 0230
W 5 0001
W 6 0000
W 7 0001
W 4 0000
W 3 0040
W 4 1234
W 6 0000
W 7 0002
W 0 022F

//--- files.f
hw/procPkg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memWb.sv
hw/proc.sv
bench/procTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module procTb -o procSim \
   && ./obj_dir/procSim | tee sim.log \
   || { echo "Build or simulation failed"; exit 1; }
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

//--- bench/procTb.sv
// Run from the project root so that bench/procVectors.txt opens. The program must halt within 500 cycles
`timescale 1ns/1ps

module procTb;

   localparam int maxCycles   = 500;
   localparam int quietCycles = 10;

   logic                          clk = 1'b0;
   logic                          rstN;
   logic                          run;
   logic                          loadEn;
   logic [procPkg::addrW-1:0]     loadAddr;
   logic [procPkg::dataW-1:0]     loadData;
   logic                          wbEn;
   logic [procPkg::regAddrW-1:0]  wbReg;
   logic [procPkg::dataW-1:0]     wbData;
   logic                          halted;
   logic                          err;

   logic [procPkg::addrW-1:0]     progAddr [$];
   logic [procPkg::dataW-1:0]     progWord [$];
   logic [procPkg::regAddrW-1:0]  expReg [$];
   logic [procPkg::dataW-1:0]     expVal [$];
   int                            errors = 0;
   int                            checks = 0;

   proc DUT (
      .clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
      .loadData(loadData), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
      .halted(halted), .err(err)
   );

   always #2 clk = ~clk;

   task automatic checkData(input string name, input logic [procPkg::dataW-1:0] expected,
                            input logic [procPkg::dataW-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic checkReg(input string name, input logic [procPkg::regAddrW-1:0] expected,
                           input logic [procPkg::regAddrW-1:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("ERROR %s expected %h actual %h", name, expected, actual);
      end
   endtask

   // P and W records; any other line is a comment
   task automatic readVectors();
      int                            fd;
      int                            code;
      logic [7:0]                    tag;
      logic [procPkg::addrW-1:0]     addr;
      logic [procPkg::regAddrW-1:0]  regIdx;
      logic [procPkg::dataW-1:0]     word;
      logic [8*100-1:0]              lineBuf;
      fd = $fopen("bench/procVectors.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open the vectors file bench/procVectors.txt");
      end else begin
         code = $fscanf(fd, " %c", tag);
         while (code == 1) begin
            if (tag == "P") begin
               code = $fscanf(fd, "%h %h", addr, word);
               progAddr.push_back(addr);
               progWord.push_back(word);
            end else if (tag == "W") begin
               code = $fscanf(fd, "%h %h", regIdx, word);
               expReg.push_back(regIdx);
               expVal.push_back(word);
            end else begin
               code = $fgets(lineBuf, fd);
            end
            code = $fscanf(fd, " %c", tag);
         end
         $fclose(fd);
      end
   endtask

   initial begin
      int cycle;
      int wIdx;
      rstN     = 1'b0;
      run      = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      cycle    = 0;
      wIdx     = 0;
      readVectors();
      if (progAddr.size() == 0 || expReg.size() == 0) begin
         errors++;
         $display("The vectors file held no program words or no expected writes");
      end
      repeat (5) @(negedge clk);
      rstN = 1'b1;
      @(negedge clk);
      #1;
      if (halted || wbEn || err) begin
         errors++;
         $display("Outputs were not idle after reset");
      end

      // Program load with run low
      foreach (progAddr[k]) begin
         @(negedge clk);
         loadEn   = 1'b1;
         loadAddr = progAddr[k];
         loadData = progWord[k];
      end
      @(negedge clk);
      loadEn = 1'b0;
      run    = 1'b1;

      // Outputs settle shortly after the falling edge
      while (!halted && cycle < maxCycles) begin
         #1;
         if (err) begin
            errors++;
            $display("err was high at cycle %0d", cycle);
         end
         if (wbEn) begin
            if (wIdx < expReg.size()) begin
               checkReg($sformatf("write %0d register", wIdx), expReg[wIdx], wbReg);
               checkData($sformatf("write %0d data", wIdx), expVal[wIdx], wbData);
            end else begin
               errors++;
               $display("Unexpected extra write to r%0d at cycle %0d", wbReg, cycle);
            end
            wIdx++;
         end
         @(negedge clk);
         cycle++;
      end

      if (!halted) begin
         errors++;
         $display("halted did not rise within %0d cycles", maxCycles);
      end
      if (wIdx < expReg.size()) begin
         errors++;
         $display("Only %0d of %0d expected writes occurred", wIdx, expReg.size());
      end

      // Core must stay quiet once halted
      repeat (quietCycles) begin
         @(negedge clk);
         #1;
         if (wbEn) begin
            errors++;
            $display("A register write occurred after halt");
         end
         if (err || !halted) begin
            errors++;
            $display("err rose or halted dropped after halt");
         end
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- hw/proc.sv
// Single-cycle top level. Load the program with run low, then raise run. halted holds until reset
`timescale 1ns/1ps

module proc (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          run,
   input  logic                          loadEn,
   input  logic [procPkg::addrW-1:0]     loadAddr,
   input  logic [procPkg::dataW-1:0]     loadData,
   output logic                          wbEn,
   output logic [procPkg::regAddrW-1:0]  wbReg,
   output logic [procPkg::dataW-1:0]     wbData,
   output logic                          halted,
   output logic                          err
);

   procPkg::instrU               instr;
   logic [procPkg::dataW-1:0]    pcInc;
   logic [procPkg::dataW-1:0]    pcNew;
   logic                         pcSrc;
   logic [procPkg::dataW-1:0]    read1Data;
   logic [procPkg::dataW-1:0]    read2Data;
   logic [procPkg::dataW-1:0]    immVal;
   logic [procPkg::aluW-1:0]     aluOp;
   logic [procPkg::brW-1:0]      branchCtl;
   logic                         aluSrc;
   logic                         lbi;
   logic                         slbi;
   logic                         jump;
   logic                         memRead;
   logic                         memWrite;
   logic                         memToReg;
   logic                         regWrite;
   logic [procPkg::regAddrW-1:0] writeReg;
   logic                         halt;
   logic [procPkg::dataW-1:0]    aluOut;
   logic [procPkg::dataW-1:0]    writeData;

   fetch fetchStage (
      .clk(clk), .rstN(rstN), .run(run), .loadEn(loadEn), .loadAddr(loadAddr),
      .loadData(loadData), .halt(halt), .pcSrc(pcSrc), .pcNew(pcNew),
      .instr(instr), .pcInc(pcInc)
   );

   decode decodeStage (
      .clk(clk), .rstN(rstN), .instr(instr), .writeData(writeData),
      .read1Data(read1Data), .read2Data(read2Data), .immVal(immVal), .aluOp(aluOp),
      .aluSrc(aluSrc), .lbi(lbi), .slbi(slbi), .branchCtl(branchCtl), .jump(jump),
      .memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
      .regWrite(regWrite), .writeReg(writeReg), .halt(halt), .err(err)
   );

   execute executeStage (
      .aluOp(aluOp), .aluSrc(aluSrc), .lbi(lbi), .slbi(slbi), .branchCtl(branchCtl),
      .jump(jump), .regData1(read1Data), .regData2(read2Data), .immVal(immVal),
      .pcInc(pcInc), .aluOut(aluOut), .pcSrc(pcSrc), .pcNew(pcNew)
   );

   memWb memWbStage (
      .clk(clk), .aluOut(aluOut), .wrData(read2Data), .memRead(memRead),
      .memWrite(memWrite), .memToReg(memToReg), .writeData(writeData)
   );

   // Sticky halt flag
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
      end else if (run && halt) begin
         halted <= 1'b1;
      end
   end

   // Commit trace for the current instruction
   assign wbEn   = regWrite & run & ~halted;
   assign wbReg  = writeReg;
   assign wbData = writeData;

endmodule

//--- hw/memWb.sv
// Data memory with combinational read and the writeback select. Only the low 8 address bits are used
`timescale 1ns/1ps

module memWb (
   input  logic                       clk,
   input  logic [procPkg::dataW-1:0]  aluOut,
   input  logic [procPkg::dataW-1:0]  wrData,
   input  logic                       memRead,
   input  logic                       memWrite,
   input  logic                       memToReg,
   output logic [procPkg::dataW-1:0]  writeData
);

   logic [procPkg::dataW-1:0] dmem [0:procPkg::dmemDepth-1];
   logic [procPkg::addrW-1:0] addr;
   logic [procPkg::dataW-1:0] readData;

   assign addr = aluOut[procPkg::addrW-1:0];

   always_ff @(posedge clk) begin
      if (memWrite) begin
         dmem[addr] <= wrData;
      end
   end

   // Read port idles at zero outside loads
   assign readData = memRead ? dmem[addr] : '0;

   assign writeData = memToReg ? readData : aluOut;

endmodule

//--- hw/execute.sv
// ALU, immediate load path and branch resolution. Branch and jump targets are PC+1 plus immVal
`timescale 1ns/1ps

module execute (
   input  logic [procPkg::aluW-1:0]   aluOp,
   input  logic                       aluSrc,
   input  logic                       lbi,
   input  logic                       slbi,
   input  logic [procPkg::brW-1:0]    branchCtl,
   input  logic                       jump,
   input  logic [procPkg::dataW-1:0]  regData1,
   input  logic [procPkg::dataW-1:0]  regData2,
   input  logic [procPkg::dataW-1:0]  immVal,
   input  logic [procPkg::dataW-1:0]  pcInc,
   output logic [procPkg::dataW-1:0]  aluOut,
   output logic                       pcSrc,
   output logic [procPkg::dataW-1:0]  pcNew
);

   logic [procPkg::dataW-1:0] opB;
   logic [procPkg::dataW-1:0] aluRes;
   logic                      isZero;
   logic                      taken;

   assign opB = aluSrc ? immVal : regData2;

   always_comb begin
      case (aluOp)
         procPkg::aluAdd:  aluRes = regData1 + opB;
         procPkg::aluSub:  aluRes = regData1 - opB;
         procPkg::aluXor:  aluRes = regData1 ^ opB;
         procPkg::aluAndn: aluRes = regData1 & ~opB;
         procPkg::aluSeq: begin
            aluRes = {{(procPkg::dataW - 1){1'b0}}, regData1 == opB};
         end
         // Signed compare
         procPkg::aluSlt: begin
            aluRes = {{(procPkg::dataW - 1){1'b0}}, $signed(regData1) < $signed(opB)};
         end
         default:          aluRes = '0;
      endcase
   end

   // lbi passes the immediate, slbi shifts the old value up a byte
   always_comb begin
      if (lbi) begin
         aluOut = immVal;
      end else if (slbi) begin
         aluOut = (regData1 << 8) | immVal;
      end else begin
         aluOut = aluRes;
      end
   end

   assign isZero = (regData1 == '0);

   always_comb begin
      case (branchCtl)
         procPkg::brEqz: taken = isZero;
         procPkg::brNez: taken = !isZero;
         default:        taken = 1'b0;
      endcase
   end

   assign pcSrc = taken | jump;
   assign pcNew = pcInc + immVal;

endmodule

//--- hw/decode.sv
// Opcode decode and the register file. Unknown opcodes and unused R-type functions raise err
`timescale 1ns/1ps

module decode (
   input  logic                          clk,
   input  logic                          rstN,
   input  procPkg::instrU                instr,
   input  logic [procPkg::dataW-1:0]     writeData,
   output logic [procPkg::dataW-1:0]     read1Data,
   output logic [procPkg::dataW-1:0]     read2Data,
   output logic [procPkg::dataW-1:0]     immVal,
   output logic [procPkg::aluW-1:0]      aluOp,
   output logic                          aluSrc,
   output logic                          lbi,
   output logic                          slbi,
   output logic [procPkg::brW-1:0]       branchCtl,
   output logic                          jump,
   output logic                          memRead,
   output logic                          memWrite,
   output logic                          memToReg,
   output logic                          regWrite,
   output logic [procPkg::regAddrW-1:0]  writeReg,
   output logic                          halt,
   output logic                          err
);

   logic [procPkg::dataW-1:0]    regs [0:2**procPkg::regAddrW-1];
   logic [procPkg::regAddrW-1:0] read2Addr;
   logic [7:0]                   imm8;
   logic [procPkg::dataW-1:0]    sImm5;
   logic [procPkg::dataW-1:0]    sImm8;
   logic [procPkg::dataW-1:0]    zImm8;
   logic [procPkg::aluW-1:0]     rFunct;

   // Immediate views of the I-format word
   assign imm8   = {instr.i.rd, instr.i.imm};
   assign sImm5  = {{(procPkg::dataW - 5){instr.i.imm[4]}}, instr.i.imm};
   assign sImm8  = {{(procPkg::dataW - 8){imm8[7]}}, imm8};
   assign zImm8  = {{(procPkg::dataW - 8){1'b0}}, imm8};
   assign rFunct = {instr.r.op[0], instr.r.funct};

   always_comb begin
      immVal    = sImm5;
      aluOp     = procPkg::aluAdd;
      aluSrc    = 1'b0;
      lbi       = 1'b0;
      slbi      = 1'b0;
      branchCtl = procPkg::brNone;
      jump      = 1'b0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      memToReg  = 1'b0;
      regWrite  = 1'b0;
      writeReg  = instr.i.rd;
      read2Addr = instr.i.rd;
      halt      = 1'b0;
      err       = 1'b0;
      case (instr.i.op)
         procPkg::opHalt: halt = 1'b1;
         procPkg::opNop: ;
         procPkg::opAddi: begin
            aluSrc   = 1'b1;
            regWrite = 1'b1;
         end
         procPkg::opXori: begin
            aluOp    = procPkg::aluXor;
            aluSrc   = 1'b1;
            regWrite = 1'b1;
         end
         procPkg::opLbi: begin
            lbi      = 1'b1;
            immVal   = sImm8;
            writeReg = instr.i.rs;
            regWrite = 1'b1;
         end
         procPkg::opSlbi: begin
            slbi     = 1'b1;
            immVal   = zImm8;
            writeReg = instr.i.rs;
            regWrite = 1'b1;
         end
         procPkg::opLd: begin
            aluSrc   = 1'b1;
            memRead  = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
         end
         // Store data comes from rd through the second read port
         procPkg::opSt: begin
            aluSrc   = 1'b1;
            memWrite = 1'b1;
         end
         procPkg::opBeqz: begin
            branchCtl = procPkg::brEqz;
            immVal    = sImm8;
         end
         procPkg::opBnez: begin
            branchCtl = procPkg::brNez;
            immVal    = sImm8;
         end
         procPkg::opJ: begin
            jump   = 1'b1;
            immVal = sImm8;
         end
         procPkg::opRtype0, procPkg::opRtype1: begin
            aluOp     = rFunct;
            read2Addr = instr.r.rt;
            writeReg  = instr.r.rd;
            if (rFunct > procPkg::aluSlt) begin
               err = 1'b1;
            end else begin
               regWrite = 1'b1;
            end
         end
         default: err = 1'b1;
      endcase
   end

   // Register file
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int k = 0; k < 2**procPkg::regAddrW; k++) begin
            regs[k] <= '0;
         end
      end else if (regWrite) begin
         regs[writeReg] <= writeData;
      end
   end

   assign read1Data = regs[instr.i.rs];
   assign read2Data = regs[read2Addr];

endmodule

//--- hw/fetch.sv
// PC and instruction memory. The program is loaded only while run is low and a nop is issued then
`timescale 1ns/1ps

module fetch (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         run,
   input  logic                         loadEn,
   input  logic [procPkg::addrW-1:0]    loadAddr,
   input  logic [procPkg::dataW-1:0]    loadData,
   input  logic                         halt,
   input  logic                         pcSrc,
   input  logic [procPkg::dataW-1:0]    pcNew,
   output procPkg::instrU               instr,
   output logic [procPkg::dataW-1:0]    pcInc
);

   logic [procPkg::dataW-1:0] pc;
   logic [procPkg::dataW-1:0] imem [0:procPkg::imemDepth-1];

   // Load port
   always_ff @(posedge clk) begin
      if (loadEn && !run) begin
         imem[loadAddr] <= loadData;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end else if (!run) begin
         pc <= '0;
      end else if (!halt) begin
         pc <= pcSrc ? pcNew : pcInc;
      end
   end

   assign pcInc = pc + 1;

   // Keep the datapath quiet during loading
   always_comb begin
      if (run) begin
         instr = imem[pc[procPkg::addrW-1:0]];
      end else begin
         instr = {procPkg::opNop, {(procPkg::dataW - procPkg::opW){1'b0}}};
      end
   end

endmodule

//--- hw/procPkg.sv
// Shared widths and encodings for the 16-bit core. Memory addresses use only the low 8 bits
package procPkg;

   localparam int dataW     = 16;
   localparam int regAddrW  = 3;
   localparam int opW       = 5;
   localparam int aluW      = 3;
   localparam int brW       = 2;
   localparam int addrW     = 8;
   localparam int imemDepth = 256;
   localparam int dmemDepth = 256;

   // Opcodes
   localparam logic [opW-1:0] opHalt = 5'b00000;
   localparam logic [opW-1:0] opNop  = 5'b00001;
   localparam logic [opW-1:0] opJ    = 5'b00100;
   localparam logic [opW-1:0] opAddi = 5'b01000;
   localparam logic [opW-1:0] opXori = 5'b01010;
   localparam logic [opW-1:0] opBeqz = 5'b01100;
   localparam logic [opW-1:0] opBnez = 5'b01101;
   localparam logic [opW-1:0] opSt   = 5'b10000;
   localparam logic [opW-1:0] opLd   = 5'b10001;
   localparam logic [opW-1:0] opSlbi = 5'b10010;
   localparam logic [opW-1:0] opLbi  = 5'b11000;

   // R-type shares the upper four opcode bits; op[0] is the top ALU code bit
   localparam logic [opW-2:0] opRtype  = 4'b1101;
   localparam logic [opW-1:0] opRtype0 = {opRtype, 1'b0};
   localparam logic [opW-1:0] opRtype1 = {opRtype, 1'b1};

   // ALU codes, equal to {op[0], funct} for R-type
   localparam logic [aluW-1:0] aluAdd  = 3'd0;
   localparam logic [aluW-1:0] aluSub  = 3'd1;
   localparam logic [aluW-1:0] aluXor  = 3'd2;
   localparam logic [aluW-1:0] aluAndn = 3'd3;
   localparam logic [aluW-1:0] aluSeq  = 3'd4;
   localparam logic [aluW-1:0] aluSlt  = 3'd5;

   // Branch conditions
   localparam logic [brW-1:0] brNone = 2'd0;
   localparam logic [brW-1:0] brEqz  = 2'd1;
   localparam logic [brW-1:0] brNez  = 2'd2;

   typedef struct packed {
      logic [opW-1:0]      op;
      logic [regAddrW-1:0] rs;
      logic [regAddrW-1:0] rt;
      logic [regAddrW-1:0] rd;
      logic [1:0]          funct;
   } rFmtT;

   // For lbi, slbi, branches and j the rd and imm fields form one 8-bit immediate
   typedef struct packed {
      logic [opW-1:0]      op;
      logic [regAddrW-1:0] rs;
      logic [regAddrW-1:0] rd;
      logic [4:0]          imm;
   } iFmtT;

   typedef union packed {
      rFmtT r;
      iFmtT i;
   } instrU;

endpackage
